//--- zports_map_pkg.sv
// I/O port map of the block: low-byte port addresses, xxAF register indices, status fields
// only the low byte of a is matched for the port addresses
`default_nettype none

package zports_map_pkg;

  // low byte of the Z80 I/O address
  localparam logic [7:0] PORT_FE     = 8'hFE; // keys, tape, beeper
  localparam logic [7:0] PORT_FD     = 8'hFD; // 7FFD paging, AY when a[15] set
  localparam logic [7:0] PORT_XT     = 8'hAF; // extended registers, index in a[15:8]
  localparam logic [7:0] PORT_COVOX  = 8'hFB;
  localparam logic [7:0] PORT_KJOY   = 8'h1F; // joystick, only outside dos
  localparam logic [7:0] PORT_KMOUSE = 8'hDF;
  localparam logic [7:0] PORT_SDCFG  = 8'h77;
  localparam logic [7:0] PORT_SDDAT  = 8'h57;

  // xxAF write indices
  localparam logic [7:0] XT_RAMPAGE   = 8'h10; // #10..#13, one per window
  localparam logic [7:0] XT_FMADDR    = 8'h15;
  localparam logic [7:0] XT_SYSCONF   = 8'h20;
  localparam logic [7:0] XT_MEMCONF   = 8'h21;
  localparam logic [7:0] XT_DMAWPD    = 8'h25;
  localparam logic [7:0] XT_INTMASK   = 8'h2A;
  localparam logic [7:0] XT_CACHECONF = 8'h2B;

  // xxAF read indices
  localparam logic [7:0] XT_STATUS  = 8'h00;
  localparam logic [7:0] XT_DMASTAT = 8'h27;

  // version bits in the low end of the status word, no FDR or VDAC here
  localparam logic [7:0] STATUS_VER = 8'h00;

endpackage

`default_nettype wire

//--- zports_cfg_pkg.sv
// data types and reset values of the port block registers
// NUM_PAGES is tied to the 2-bit window index of the #10..#13 registers
`default_nettype none

package zports_cfg_pkg;

  typedef logic [7:0] byte_t;
  typedef logic [7:0] xt_index_t;

  localparam int NUM_PAGES = 4;

  // window pages after reset
  localparam logic [7:0] RST_PAGE0 = 8'h00; // ROM
  localparam logic [7:0] RST_PAGE1 = 8'h05;
  localparam logic [7:0] RST_PAGE2 = 8'h02;
  localparam logic [7:0] RST_PAGE3 = 8'h00;

  localparam logic [7:0] RST_MEMCONF = 8'h04; // no map
  localparam logic [7:0] RST_INTMASK = 8'h01; // frame interrupt only
  localparam logic [7:0] RST_SYSCONF = 8'h00; // 3.5 MHz

endpackage

`default_nettype wire

//--- port_decoder.sv
// Z80 I/O address decode, all outputs combinational from a and the I/O strobes
// iord_s/iowr_s must be single-cycle pulses on clk; the 7FFD lock is applied downstream
`timescale 1ns/1ps
`default_nettype none

module port_decoder
  import zports_map_pkg::*, zports_cfg_pkg::*;
(
  input  logic [15:0] a,
  input  logic        regs_we,
  input  logic        iord,
  input  logic        iowr,
  input  logic        iord_s,
  input  logic        iowr_s,
  input  logic        dos,
  output xt_index_t   xt_index,
  output logic        porthit,
  output logic        external_port,
  output logic        dataout,
  output logic        xt_wr,
  output logic        xt_status_rd,
  output logic        pfd_wr,
  output logic        sdcfg_wr,
  output logic        sd_start,
  output logic        sd_write,
  output logic        beeper_wr,
  output logic        covox_wr,
  output logic        ay_bc1,
  output logic        ay_bdir
);

  byte_t loa;
  logic  hit_fe, hit_fd, hit_xt, hit_covox;
  logic  hit_kjoy, hit_kmouse, hit_sdcfg, hit_sddat;
  logic  ay_hit;

  assign loa      = a[7:0];
  assign xt_index = regs_we ? a[7:0] : a[15:8]; // direct register writes carry index in low byte

  assign hit_fe     = (loa == PORT_FE);
  assign hit_fd     = (loa == PORT_FD);
  assign hit_xt     = (loa == PORT_XT);
  assign hit_covox  = (loa == PORT_COVOX);
  assign hit_kjoy   = (loa == PORT_KJOY) && !dos; // 1F belongs to the floppy in dos
  assign hit_kmouse = (loa == PORT_KMOUSE);
  assign hit_sdcfg  = (loa == PORT_SDCFG);
  assign hit_sddat  = (loa == PORT_SDDAT);

  assign porthit = hit_fe || hit_xt || hit_fd || hit_covox || hit_kjoy || hit_kmouse
                || hit_sdcfg || hit_sddat;

  assign ay_hit        = hit_fd && a[15]; // BFFD/FFFD
  assign external_port = ay_hit;
  assign dataout       = porthit && iord && !external_port;

  // write and read strobes
  assign xt_wr        = (hit_xt && iowr_s) || regs_we;
  assign xt_status_rd = hit_xt && iord_s && (xt_index == XT_STATUS);
  assign pfd_wr       = hit_fd && !a[15] && iowr_s;
  assign sdcfg_wr     = hit_sdcfg && iowr_s;
  assign sd_start     = hit_sddat && (iowr_s || iord_s);
  assign sd_write     = hit_sddat && iowr; // level, spans the whole write cycle
  assign beeper_wr    = hit_fe && iowr_s;
  assign covox_wr     = hit_covox && iowr_s;

  // AY bus control
  assign ay_bc1  = ay_hit && a[14] && (iord || iowr);
  assign ay_bdir = ay_hit && iowr;

endmodule

`default_nettype wire

//--- memory_pager.sv
// window page registers, memconf and classic 7FFD paging with the 48K lock
// memconf lock mode 2 behaves as mode 0 here
`timescale 1ns/1ps
`default_nettype none

module memory_pager
  import zports_map_pkg::*, zports_cfg_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  byte_t                  din,
  input  xt_index_t              xt_index,
  input  logic                   xt_wr,
  input  logic                   pfd_wr,
  output logic [NUM_PAGES*8-1:0] xt_page,
  output byte_t                  memconf,
  output byte_t                  page2,
  output byte_t                  page3
);

  byte_t page [NUM_PAGES];
  logic  lock48;
  logic  lock_mode3;
  logic  pfd_ok;
  logic  [2:0] pfd_hi; // page 3 bits 5:3 from a 7FFD write

  assign lock_mode3 = (memconf[7:6] == 2'b11);
  assign pfd_ok     = pfd_wr && !lock48;

  // mode 3 maps 1024K, otherwise 512K or 128K when memconf[6] is set
  assign pfd_hi = lock_mode3 ? {din[5], din[7:6]}
                             : {1'b0, memconf[6] ? 2'b00 : din[7:6]};

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      page[0] <= RST_PAGE0;
      page[1] <= RST_PAGE1;
      page[2] <= RST_PAGE2;
      page[3] <= RST_PAGE3;
      memconf <= RST_MEMCONF;
    end
    else if (pfd_ok) // 7FFD wins over a same-cycle xxAF write
    begin
      memconf[0] <= din[4]; // ROM select
      page[3]    <= {2'b00, pfd_hi, din[2:0]};
    end
    else if (xt_wr)
    begin
      if (xt_index[7:2] == XT_RAMPAGE[7:2])
        page[xt_index[1:0]] <= din;
      if (xt_index == XT_MEMCONF)
        memconf <= din;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      lock48 <= 1'b0;
    else if (pfd_ok && !lock_mode3)
      lock48 <= din[5];
  end

  assign xt_page = {page[3], page[2], page[1], page[0]};
  assign page2   = page[2];
  assign page3   = page[3];

  lock48_stable_a: assert property (@(posedge clk) disable iff (rst)
    !pfd_wr |=> $stable(lock48))
    else $error("lock48 changed without a 7FFD write");

endmodule

`default_nettype wire

//--- sys_config_regs.sv
// system configuration registers reached through xxAF
// pwr_up comes only from its initial value, so it needs an FPGA with register init
`timescale 1ns/1ps
`default_nettype none

module sys_config_regs
  import zports_map_pkg::*, zports_cfg_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  byte_t      din,
  input  xt_index_t  xt_index,
  input  logic       xt_wr,
  input  logic       xt_status_rd,
  output byte_t      sysconf,
  output logic [3:0] cacheconf,
  output logic [4:0] fmaddr,
  output byte_t      intmask,
  output logic [1:0] dmawpdev,
  output logic       pwr_up
);

  logic pwr_up_r = 1'b1; // set at configuration

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      fmaddr[4] <= 1'b0;     // FM window off
      intmask   <= RST_INTMASK;
      sysconf   <= RST_SYSCONF;
      cacheconf <= 4'h0;     // no cache
    end
    else if (xt_wr)
    begin
      if (xt_index == XT_FMADDR)
        fmaddr <= din[4:0];
      if (xt_index == XT_SYSCONF)
      begin
        sysconf   <= din;
        cacheconf <= {4{din[2]}}; // cache follows the turbo bit
      end
      if (xt_index == XT_CACHECONF)
        cacheconf <= din[3:0];
      if (xt_index == XT_DMAWPD)
        dmawpdev <= din[1:0];
      if (xt_index == XT_INTMASK)
        intmask <= din;
    end
  end

  // cleared by the first status read
  always_ff @(posedge clk)
  begin
    if (xt_status_rd)
      pwr_up_r <= 1'b0;
  end

  assign pwr_up = pwr_up_r;

endmodule

`default_nettype wire

//--- sd_port.sv
// Z-controller compatible SD interface: chip selects and SPI data byte
`timescale 1ns/1ps
`default_nettype none

module sd_port
  import zports_cfg_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  byte_t din,
  input  logic  sdcfg_wr,
  input  logic  sd_write,
  output logic  sdcs_n,
  output logic  sd2cs_n,
  output byte_t sd_datain
);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      sdcs_n  <= 1'b1;
      sd2cs_n <= 1'b1;
    end
    else if (sdcfg_wr)
    begin
      sdcs_n  <= din[1];
      sd2cs_n <= ~din[3]; // second card select is active high in the register
    end
  end

  // reads shift out FF
  assign sd_datain = sd_write ? din : 8'hFF;

  cs_after_rst_a: assert property (@(posedge clk) rst |=> (sdcs_n && sd2cs_n))
    else $error("SD chip selects not released after reset");

endmodule

`default_nettype wire

//--- port_read_mux.sv
// read data for the internal ports; only meaningful while dataout is high
`timescale 1ns/1ps
`default_nettype none

module port_read_mux
  import zports_map_pkg::*, zports_cfg_pkg::*;
(
  input  logic [15:0] a,
  input  xt_index_t   xt_index,
  input  logic        dos,
  input  logic        tape_read,
  input  logic [4:0]  keys_in,
  input  byte_t       kj_in,
  input  byte_t       mus_in,
  input  byte_t       sd_dataout,
  input  logic        dma_act,
  input  logic        pwr_up,
  input  byte_t       page2,
  input  byte_t       page3,
  output byte_t       dout
);

  byte_t xt_dout;

  always_comb
  begin
    case (xt_index)
      XT_STATUS:              xt_dout = {1'b0, pwr_up, 3'b000, STATUS_VER[2:0]};
      XT_DMASTAT:             xt_dout = {dma_act, 7'b0};
      XT_RAMPAGE + 8'd2:      xt_dout = page2;
      XT_RAMPAGE + 8'd3:      xt_dout = page3;
      default:                xt_dout = 8'hFF;
    endcase
  end

  always_comb
  begin
    case (a[7:0])
      PORT_FE:     dout = {1'b1, tape_read, 1'b1, keys_in};
      PORT_XT:     dout = xt_dout;
      PORT_KJOY:   dout = dos ? 8'hFF : kj_in; // floppy owns 1F in dos
      PORT_KMOUSE: dout = mus_in;
      PORT_SDCFG:  dout = 8'h00;               // card present, not write protected
      PORT_SDDAT:  dout = sd_dataout;
      default:     dout = 8'hFF;
    endcase
  end

endmodule

`default_nettype wire

//--- zports_top.sv
// I/O port block of the core, everything on clk
`timescale 1ns/1ps
`default_nettype none

module zports_top
  import zports_cfg_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  byte_t                  din,
  input  logic [15:0]            a,
  input  logic                   regs_we,
  input  logic                   iord,
  input  logic                   iowr,
  input  logic                   iord_s,
  input  logic                   iowr_s,
  input  logic                   dos,
  input  logic                   tape_read,
  input  logic [4:0]             keys_in,
  input  byte_t                  kj_in,
  input  byte_t                  mus_in,
  input  byte_t                  sd_dataout,
  input  logic                   dma_act,
  output byte_t                  dout,
  output logic                   dataout,
  output logic                   porthit,
  output logic                   external_port,
  output logic [NUM_PAGES*8-1:0] xt_page,
  output byte_t                  memconf,
  output byte_t                  sysconf,
  output logic [3:0]             cacheconf,
  output logic [4:0]             fmaddr,
  output byte_t                  intmask,
  output logic [1:0]             dmawpdev,
  output logic                   ay_bdir,
  output logic                   ay_bc1,
  output logic                   covox_wr,
  output logic                   beeper_wr,
  output logic                   sdcs_n,
  output logic                   sd2cs_n,
  output logic                   sd_start,
  output byte_t                  sd_datain
);

  xt_index_t xt_index;
  logic      xt_wr, xt_status_rd, pfd_wr;
  logic      sdcfg_wr, sd_write;
  logic      pwr_up;
  byte_t     page2, page3;

  port_decoder dec_i (
    .a             (a),
    .regs_we       (regs_we),
    .iord          (iord),
    .iowr          (iowr),
    .iord_s        (iord_s),
    .iowr_s        (iowr_s),
    .dos           (dos),
    .xt_index      (xt_index),
    .porthit       (porthit),
    .external_port (external_port),
    .dataout       (dataout),
    .xt_wr         (xt_wr),
    .xt_status_rd  (xt_status_rd),
    .pfd_wr        (pfd_wr),
    .sdcfg_wr      (sdcfg_wr),
    .sd_start      (sd_start),
    .sd_write      (sd_write),
    .beeper_wr     (beeper_wr),
    .covox_wr      (covox_wr),
    .ay_bc1        (ay_bc1),
    .ay_bdir       (ay_bdir)
  );

  memory_pager pager_i (
    .clk      (clk),
    .rst      (rst),
    .din      (din),
    .xt_index (xt_index),
    .xt_wr    (xt_wr),
    .pfd_wr   (pfd_wr),
    .xt_page  (xt_page),
    .memconf  (memconf),
    .page2    (page2),
    .page3    (page3)
  );

  sys_config_regs cfg_i (
    .clk          (clk),
    .rst          (rst),
    .din          (din),
    .xt_index     (xt_index),
    .xt_wr        (xt_wr),
    .xt_status_rd (xt_status_rd),
    .sysconf      (sysconf),
    .cacheconf    (cacheconf),
    .fmaddr       (fmaddr),
    .intmask      (intmask),
    .dmawpdev     (dmawpdev),
    .pwr_up       (pwr_up)
  );

  sd_port sd_i (
    .clk       (clk),
    .rst       (rst),
    .din       (din),
    .sdcfg_wr  (sdcfg_wr),
    .sd_write  (sd_write),
    .sdcs_n    (sdcs_n),
    .sd2cs_n   (sd2cs_n),
    .sd_datain (sd_datain)
  );

  port_read_mux rd_i (
    .a          (a),
    .xt_index   (xt_index),
    .dos        (dos),
    .tape_read  (tape_read),
    .keys_in    (keys_in),
    .kj_in      (kj_in),
    .mus_in     (mus_in),
    .sd_dataout (sd_dataout),
    .dma_act    (dma_act),
    .pwr_up     (pwr_up),
    .page2      (page2),
    .page3      (page3),
    .dout       (dout)
  );

endmodule

`default_nettype wire

//--- zports_checker.sv
// compares DUT outputs with the expectations driven by the testbench
// samples on the falling clock edge, where the combinational outputs have settled
`timescale 1ns/1ps
`default_nettype none

module zports_checker (
  input  logic        clk,
  input  logic        en_flags,
  input  logic        en_dout,
  input  logic        en_page,
  input  logic [45:0] misc_mask,
  input  logic [6:0]  exp_flags,
  input  logic [7:0]  exp_dout,
  input  logic [31:0] exp_page,
  input  logic [45:0] exp_misc,
  input  logic        porthit,
  input  logic        external_port,
  input  logic        dataout,
  input  logic        ay_bdir,
  input  logic        ay_bc1,
  input  logic        beeper_wr,
  input  logic        covox_wr,
  input  logic [7:0]  dout,
  input  logic [31:0] xt_page,
  input  logic [7:0]  sd_datain,
  input  logic [7:0]  intmask,
  input  logic [3:0]  cacheconf,
  input  logic [7:0]  memconf,
  input  logic [7:0]  sysconf,
  input  logic [4:0]  fmaddr,
  input  logic [1:0]  dmawpdev,
  input  logic        sdcs_n,
  input  logic        sd2cs_n,
  input  logic        sd_start,
  output int          errors,
  output int          samples
);

  logic [6:0]  act_flags;
  logic [45:0] act_misc;

  assign act_flags = {porthit, external_port, dataout, ay_bdir, ay_bc1, beeper_wr, covox_wr};
  assign act_misc  = {sd_datain, intmask, cacheconf, memconf, sdcs_n, sd2cs_n, sd_start,
                      sysconf, fmaddr, dmawpdev};

  initial
  begin
    errors  = 0;
    samples = 0;
  end

  always @(negedge clk)
  begin
    if (en_flags || en_dout || en_page || (misc_mask != '0))
    begin
      samples = samples + 1;
      if (en_flags && (act_flags !== exp_flags))
      begin
        $display("** Error at time %0t: porthit/ext/dataout/bdir/bc1/beeper/covox %b, expected %b",
                 $time, act_flags, exp_flags);
        errors = errors + 1;
      end
      if (en_dout && (dout !== exp_dout))
      begin
        $display("** Error at time %0t: dout %h, expected %h", $time, dout, exp_dout);
        errors = errors + 1;
      end
      if (en_page && (xt_page !== exp_page))
      begin
        $display("** Error at time %0t: xt_page %h, expected %h", $time, xt_page, exp_page);
        errors = errors + 1;
      end
      if ((act_misc & misc_mask) !== (exp_misc & misc_mask)) // sd, config regs, cs
      begin
        $display("** Error at time %0t: status fields %h, expected %h (mask %h)",
                 $time, act_misc & misc_mask, exp_misc & misc_mask, misc_mask);
        errors = errors + 1;
      end
    end
  end

endmodule

`default_nettype wire

//--- tb_zports.sv
// testbench of the I/O port block, expectations come from a shadow register model
// inputs change 2 ns after the rising edge, the checker samples on the falling edge
`timescale 1ns/1ps
`default_nettype none

module tb_zports
  import zports_map_pkg::*;
();

  localparam logic [45:0] ALL_MISC = '1;
  localparam logic [45:0] RST_MISC = ALL_MISC & ~46'h3F; // leaves out fmaddr[3:0] and dmawpdev

  logic        clk = 1'b0;
  logic        rst;
  logic [7:0]  din;
  logic [15:0] a;
  logic        regs_we, iord, iowr, iord_s, iowr_s, dos;
  logic        tape_read;
  logic [4:0]  keys_in;
  logic [7:0]  kj_in, mus_in, sd_dataout;
  logic        dma_act;
  logic [7:0]  dout;
  logic        dataout, porthit, external_port;
  logic [31:0] xt_page;
  logic [7:0]  memconf, sysconf, intmask;
  logic [3:0]  cacheconf;
  logic [4:0]  fmaddr;
  logic [1:0]  dmawpdev;
  logic        ay_bdir, ay_bc1, covox_wr, beeper_wr;
  logic        sdcs_n, sd2cs_n, sd_start;
  logic [7:0]  sd_datain;

  // expectations handed to the checker
  logic        en_flags, en_dout, en_page;
  logic [45:0] misc_mask, exp_misc;
  logic [6:0]  exp_flags;
  logic [7:0]  exp_dout;
  logic [31:0] exp_page;
  int          errors, samples;

  // shadow of the DUT registers
  logic [7:0]  sh_page [4];
  logic [7:0]  sh_memconf, sh_intmask, sh_sysconf;
  logic [3:0]  sh_cacheconf;
  logic [4:0]  sh_fmaddr;
  logic [1:0]  sh_dmawpdev;
  logic        sh_lock48, sh_pwr_up, sh_sdcs_n, sh_sd2cs_n;
  logic [31:0] seed;

  zports_top dut_i (.*);

  zports_checker chk_i (.*);

  always #20 clk = ~clk; // 40 ns period

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [7:0] port_at(input logic [2:0] n);
    case (n)
      3'd0:    return PORT_FE;
      3'd1:    return PORT_FD;
      3'd2:    return PORT_XT;
      3'd3:    return PORT_COVOX;
      3'd4:    return PORT_KJOY;
      3'd5:    return PORT_KMOUSE;
      3'd6:    return PORT_SDCFG;
      default: return PORT_SDDAT;
    endcase
  endfunction

  // {porthit, external_port, dataout, ay_bdir, ay_bc1, beeper_wr, covox_wr}
  function automatic logic [6:0] ref_flags(input logic [15:0] addr, input logic dos_i,
                                           input logic rd, input logic wr, input logic wr_s);
    logic [7:0] lo;
    logic       hit;
    logic       ext;
    lo  = addr[7:0];
    hit = (lo == PORT_FE) || (lo == PORT_XT) || (lo == PORT_FD) || (lo == PORT_COVOX)
       || (lo == PORT_KMOUSE) || (lo == PORT_SDCFG) || (lo == PORT_SDDAT)
       || ((lo == PORT_KJOY) && !dos_i);
    ext = (lo == PORT_FD) && addr[15];
    return {hit, ext, hit && rd && !ext, ext && wr, ext && addr[14] && (rd || wr),
            (lo == PORT_FE) && wr_s, (lo == PORT_COVOX) && wr_s};
  endfunction

  function automatic logic [7:0] ref_dout(input logic [15:0] addr);
    logic [7:0] r;
    r = 8'hFF;
    case (addr[7:0])
      PORT_FE:     r = {1'b1, tape_read, 1'b1, keys_in};
      PORT_XT:
        if (addr[15:8] == 8'h00)
          r = {1'b0, sh_pwr_up, 6'b0}; // status, version bits zero
        else if (addr[15:8] == 8'h27)
          r = {dma_act, 7'b0};
        else if (addr[15:8] == 8'h12)
          r = sh_page[2];
        else if (addr[15:8] == 8'h13)
          r = sh_page[3];
      PORT_KJOY:   r = dos ? 8'hFF : kj_in;
      PORT_KMOUSE: r = mus_in;
      PORT_SDCFG:  r = 8'h00;
      PORT_SDDAT:  r = sd_dataout;
      default:     r = 8'hFF;
    endcase
    return r;
  endfunction

  // new page 3 after an accepted 7FFD write
  function automatic logic [7:0] pfd_page3(input logic [7:0] mc, input logic [7:0] d);
    logic [7:0] p;
    p = {5'b00000, d[2:0]};
    if (mc[7:6] == 2'b11)
    begin
      p[5] = d[5];
      p[4] = d[7];
      p[3] = d[6];
    end
    else if (!mc[6])
      p[4:3] = d[7:6]; // 512K, memconf[6] limits to 128K
    return p;
  endfunction

  task automatic model_xt(input logic [7:0] idx, input logic [7:0] d);
    if (idx >= XT_RAMPAGE && idx <= XT_RAMPAGE + 8'd3)
      sh_page[idx[1:0]] = d;
    if (idx == XT_MEMCONF)
      sh_memconf = d;
    if (idx == XT_SYSCONF)
    begin
      sh_sysconf   = d;
      sh_cacheconf = {4{d[2]}};
    end
    if (idx == XT_CACHECONF)
      sh_cacheconf = d[3:0]; // same-cycle cacheconf wins
    if (idx == XT_FMADDR)
      sh_fmaddr = d[4:0];
    if (idx == XT_DMAWPD)
      sh_dmawpdev = d[1:0];
    if (idx == XT_INTMASK)
      sh_intmask = d;
  endtask

  task automatic model_pfd(input logic [7:0] d);
    if (!sh_lock48)
    begin
      sh_page[3]    = pfd_page3(sh_memconf, d);
      sh_memconf[0] = d[4];
      if (sh_memconf[7:6] != 2'b11)
        sh_lock48 = d[5];
    end
  endtask

  task automatic idle_bus();
    a         = 16'h0000;
    din       = 8'h00;
    regs_we   = 1'b0;
    iord      = 1'b0;
    iowr      = 1'b0;
    iord_s    = 1'b0;
    iowr_s    = 1'b0;
    en_flags  = 1'b0;
    en_dout   = 1'b0;
    en_page   = 1'b0;
    misc_mask = '0;
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic await_sample();
    int start;
    int waited;
    start  = samples;
    waited = 0;
    while (samples == start && waited < 4)
    begin
      @(negedge clk);
      #1;
      waited++;
    end
    if (samples == start)
    begin
      $display("timeout: the checker took no sample within 4 clock cycles");
      $display("%0d samples checked, %0d errors", samples, errors);
      $display("Simulation failed");
      $finish;
    end
  endtask

  // publish expectations for the current inputs, let the checker sample, then free the bus
  task automatic check_cycle(input logic f_en, input logic d_en, input logic p_en,
                             input logic [45:0] mask, input logic [7:0] e_datain,
                             input logic e_start);
    exp_flags = ref_flags(a, dos, iord, iowr, iowr_s);
    exp_dout  = ref_dout(a);
    exp_page  = {sh_page[3], sh_page[2], sh_page[1], sh_page[0]};
    exp_misc  = {e_datain, sh_intmask, sh_cacheconf, sh_memconf, sh_sdcs_n, sh_sd2cs_n,
                 e_start, sh_sysconf, sh_fmaddr, sh_dmawpdev};
    en_flags  = f_en;
    en_dout   = d_en;
    en_page   = p_en;
    misc_mask = mask;
    await_sample();
    next_cycle();
    idle_bus();
  endtask

  task automatic io_write(input logic [15:0] addr, input logic [7:0] d);
    a      = addr;
    din    = d;
    iowr   = 1'b1;
    iowr_s = 1'b1;
    next_cycle();
    idle_bus();
  endtask

  task automatic reg_write(input logic [7:0] idx, input logic [7:0] d);
    a       = {8'h00, idx}; // index in the low byte
    din     = d;
    regs_we = 1'b1;
    next_cycle();
    idle_bus();
  endtask

  task automatic read_port(input logic [15:0] addr);
    a      = addr;
    iord   = 1'b1;
    iord_s = 1'b1;
    check_cycle(1'b1, 1'b1, 1'b0, ALL_MISC, 8'hFF, addr[7:0] == PORT_SDDAT);
    if (addr == {XT_STATUS, PORT_XT})
      sh_pwr_up = 1'b0;
  endtask

  initial
  begin
    logic [7:0] d;
    logic [7:0] idx;
    logic [7:0] mc;
    seed = 32'd23659;
    idle_bus();
    rst        = 1'b1;
    dos        = 1'b0;
    tape_read  = 1'b1;
    keys_in    = 5'h15;
    kj_in      = 8'h3C;
    mus_in     = 8'hA5;
    sd_dataout = 8'h5A;
    dma_act    = 1'b1;
    sh_page[0] = 8'h00;
    sh_page[1] = 8'h05;
    sh_page[2] = 8'h02;
    sh_page[3] = 8'h00;
    sh_memconf   = 8'h04;
    sh_intmask   = 8'h01;
    sh_sysconf   = 8'h00;
    sh_cacheconf = 4'h0;
    sh_fmaddr    = 5'h00;
    sh_dmawpdev  = 2'b00;
    sh_lock48    = 1'b0;
    sh_pwr_up    = 1'b1;
    sh_sdcs_n    = 1'b1;
    sh_sd2cs_n   = 1'b1;
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;

    // reset values, then power-up flag set once
    check_cycle(1'b0, 1'b0, 1'b1, RST_MISC, 8'hFF, 1'b0);
    for (int k = 0; k < 3; k++)
    begin
      idx  = (k == 0) ? XT_FMADDR : (k == 1) ? XT_DMAWPD : XT_INTMASK;
      seed = lcg(seed);
      d    = seed[23:16];
      reg_write(idx, d);
      model_xt(idx, d);
    end
    check_cycle(1'b0, 1'b0, 1'b0, ALL_MISC, 8'hFF, 1'b0);
    read_port({XT_STATUS, PORT_XT});
    read_port({XT_STATUS, PORT_XT});

    // window pages through xxAF, then through regs_we
    for (int i = 0; i < 16; i++)
    begin
      idx  = XT_RAMPAGE + i[1:0];
      seed = lcg(seed);
      d    = seed[23:16];
      if (i >= 8)
        reg_write(idx, d);
      else
        io_write({idx, PORT_XT}, d);
      model_xt(idx, d);
      check_cycle(1'b0, 1'b0, 1'b1, ALL_MISC, 8'hFF, 1'b0);
      if (i[1])
        read_port({idx, PORT_XT}); // pages 2 and 3 read back
    end

    // 7FFD paging in lock modes 0, 1 and 3
    for (int m = 0; m < 3; m++)
    begin
      mc = (m == 0) ? 8'h04 : (m == 1) ? 8'h44 : 8'hC4;
      io_write({XT_MEMCONF, PORT_XT}, mc);
      model_xt(XT_MEMCONF, mc);
      for (int k = 0; k < 4; k++)
      begin
        seed = lcg(seed);
        d    = seed[23:16];
        if (m < 2)
          d[5] = 1'b0; // keep 48K lock open
        io_write(16'h7FFD, d);
        model_pfd(d);
        check_cycle(1'b0, 1'b0, 1'b1, ALL_MISC, 8'hFF, 1'b0);
      end
    end
    io_write({XT_MEMCONF, PORT_XT}, 8'h04);
    model_xt(XT_MEMCONF, 8'h04);
    for (int k = 0; k < 4; k++)
    begin
      seed = lcg(seed);
      d    = (k == 0) ? 8'h23 : seed[23:16]; // first write locks
      io_write(16'h7FFD, d);
      model_pfd(d);
      check_cycle(1'b0, 1'b0, 1'b1, ALL_MISC, 8'hFF, 1'b0);
    end

    // sysconf drives cacheconf until cacheconf is written
    for (int k = 0; k < 2; k++)
    begin
      seed = lcg(seed);
      d    = seed[23:16];
      d[2] = k[0];
      io_write({XT_SYSCONF, PORT_XT}, d);
      model_xt(XT_SYSCONF, d);
      check_cycle(1'b0, 1'b0, 1'b0, ALL_MISC, 8'hFF, 1'b0);
      seed = lcg(seed);
      d    = seed[23:16];
      io_write({XT_CACHECONF, PORT_XT}, d);
      model_xt(XT_CACHECONF, d);
      check_cycle(1'b0, 1'b0, 1'b0, ALL_MISC, 8'hFF, 1'b0);
    end

    // decode flags for random addresses, levels only so no register changes
    for (int k = 0; k < 40; k++)
    begin
      seed = lcg(seed);
      a    = seed[31:16];
      if (seed[15])
        a[7:0] = port_at(seed[14:12]);
      seed      = lcg(seed);
      dos       = seed[31];
      dma_act   = seed[30];
      tape_read = seed[29];
      keys_in   = seed[28:24];
      kj_in     = seed[23:16];
      mus_in    = ~seed[23:16];
      if (seed[15])
        iord = 1'b1;
      else
        iowr = 1'b1;
      check_cycle(1'b1, iord, 1'b0, 46'h0, 8'hFF, 1'b0);
    end
    dos = 1'b0;

    // AY bus control, then beeper and covox strobes
    for (int k = 0; k < 4; k++)
    begin
      a = (k == 0) ? 16'hFFFD : (k == 1) ? 16'hBFFD
        : (k == 2) ? {8'h00, PORT_FE} : {8'h00, PORT_COVOX};
      if (k == 0)
        iord = 1'b1;
      else
      begin
        iowr   = 1'b1;
        iowr_s = 1'b1;
      end
      check_cycle(1'b1, iord, 1'b0, 46'h0, 8'hFF, 1'b0);
    end

    // SD card port
    for (int k = 0; k < 3; k++)
    begin
      seed = lcg(seed);
      d    = seed[23:16];
      io_write({8'h00, PORT_SDCFG}, d);
      sh_sdcs_n  = d[1];
      sh_sd2cs_n = ~d[3];
      check_cycle(1'b0, 1'b0, 1'b0, ALL_MISC, 8'hFF, 1'b0);
      seed   = lcg(seed);
      d      = seed[23:16];
      a      = {8'h00, PORT_SDDAT};
      din    = d;
      iowr   = 1'b1;
      iowr_s = 1'b1;
      check_cycle(1'b1, 1'b0, 1'b0, ALL_MISC, d, 1'b1);
      sd_dataout = seed[31:24];
      read_port({8'h00, PORT_SDDAT});
    end

    $display("%0d samples checked, %0d errors", samples, errors);
    if (errors == 0 && samples > 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
zports_map_pkg.sv
zports_cfg_pkg.sv
port_decoder.sv
memory_pager.sv
sys_config_regs.sv
sd_port.sv
port_read_mux.sv
zports_top.sv
zports_checker.sv
tb_zports.sv

//--- Bender.yml
package:
  name: zports

sources:
  - files:
      - zports_map_pkg.sv
      - zports_cfg_pkg.sv
      - port_decoder.sv
      - memory_pager.sv
      - sys_config_regs.sv
      - sd_port.sv
      - port_read_mux.sv
      - zports_top.sv
  - target: test
    files:
      - zports_checker.sv
      - tb_zports.sv
